//--- Bender.yml
package:
  name: on_chip_periph

sources:
  - src/periphPkg.sv
  - src/prescaler.sv
  - src/periphBus.sv
  - src/freeRunTimer.sv
  - src/intervalTimer.sv
  - src/intController.sv
  - src/onChipPeriph.sv
  - target: test
    files:
      - test/onChipPeriph_props.sv
      - test/tb_onChipPeriph.sv

//--- list.f
src/periphPkg.sv
src/prescaler.sv
src/periphBus.sv
src/freeRunTimer.sv
src/intervalTimer.sv
src/intController.sv
src/onChipPeriph.sv
test/onChipPeriph_props.sv
test/tb_onChipPeriph.sv

//--- src/freeRunTimer.sv
`timescale 1ns/1ps
`default_nettype none

module freeRunTimer import periphPkg::*; (
	input  wire                CLK,
	input  wire                RST_N,
	input  wire regReq_t       regReq,
	input  wire                sel,
	input  wire prescaleTaps_t taps,
	output regData_t           rdData,
	output logic               cmpIrq,
	output logic               ovfIrq
);

	regData_t   count;
	regData_t   compare;
	logic [1:0] clkSel;
	logic       clrOnMatch;
	logic       cmpIe;
	logic       ovfIe;
	logic       cmpFlag;
	logic       ovfFlag;
	logic       tick;
	logic       match;
	logic       wrap;
	logic       wrEn;

	assign wrEn = sel && regReq.write;

	// Clock select 0 keeps the counter stopped
	always_comb begin
		case (clkSel)
			2'd1: tick = taps.ce8;
			2'd2: tick = taps.ce32;
			2'd3: tick = taps.ce128;
			default: tick = 1'b0;
		endcase
	end

	assign match = tick && count == compare;
	assign wrap = tick && count == '1;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			count <= '0;
			compare <= '0;
			clkSel <= '0;
			clrOnMatch <= 1'b0;
			cmpIe <= 1'b0;
			ovfIe <= 1'b0;
			cmpFlag <= 1'b0;
			ovfFlag <= 1'b0;
		end else begin
			if (wrEn && regReq.offset == 2'd0)
				count <= regReq.wrData;
			else if (match && clrOnMatch)
				count <= '0;
			else if (tick)
				count <= count + 16'd1;

			if (wrEn && regReq.offset == 2'd1)
				compare <= regReq.wrData;

			if (wrEn && regReq.offset == 2'd2) begin
				clkSel <= regReq.wrData[1:0];
				clrOnMatch <= regReq.wrData[2];
				cmpIe <= regReq.wrData[4];
				ovfIe <= regReq.wrData[5];
			end

			// A new event wins over a clear in the same cycle
			cmpFlag <= (cmpFlag && !(wrEn && regReq.offset == 2'd3 && regReq.wrData[0])) || match;
			ovfFlag <= (ovfFlag && !(wrEn && regReq.offset == 2'd3 && regReq.wrData[1])) || wrap;
		end
	end

	always_comb begin
		case (regReq.offset)
			2'd0: rdData = count;
			2'd1: rdData = compare;
			2'd2: rdData = {10'd0, ovfIe, cmpIe, 1'b0, clrOnMatch, clkSel};
			default: rdData = {14'd0, ovfFlag, cmpFlag};
		endcase
	end

	assign cmpIrq = cmpFlag && cmpIe;
	assign ovfIrq = ovfFlag && ovfIe;

endmodule

`default_nettype wire

//--- src/intController.sv
`timescale 1ns/1ps
`default_nettype none

module intController import periphPkg::*; (
	input  wire          CLK,
	input  wire          RST_N,
	input  wire regReq_t regReq,
	input  wire          sel,
	output regData_t     rdData,
	input  wire          frtCmpIrq,
	input  wire          frtOvfIrq,
	input  wire          itmIrq,
	output logic         intReq,
	output intLevel_t    intLvl,
	output intVector_t   intVec
);

	intLevel_t  frtLvl;
	intLevel_t  itmLvl;
	intVector_t cmpVec;
	intVector_t ovfVec;
	intVector_t itmVec;
	intLevel_t  mask;
	intLevel_t  bestLvl;
	intVector_t bestVec;
	logic       found;
	logic       wrEn;

	assign wrEn = sel && regReq.write;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			frtLvl <= '0;
			itmLvl <= '0;
			cmpVec <= '0;
			ovfVec <= '0;
			itmVec <= '0;
			mask <= '0;
		end else if (wrEn) begin
			case (regReq.offset)
				2'd0: {itmLvl, frtLvl} <= regReq.wrData[7:0];
				2'd1: {ovfVec, cmpVec} <= regReq.wrData;
				2'd2: itmVec <= regReq.wrData[7:0];
				default: mask <= regReq.wrData[3:0];
			endcase
		end
	end

	always_comb begin
		case (regReq.offset)
			2'd0: rdData = {8'd0, itmLvl, frtLvl};
			2'd1: rdData = {ovfVec, cmpVec};
			2'd2: rdData = {8'd0, itmVec};
			default: rdData = {12'd0, mask};
		endcase
	end

	// Strictly greater keeps the earlier source on a tie
	always_comb begin
		bestLvl = mask;
		bestVec = '0;
		found = 1'b0;
		if (frtCmpIrq && frtLvl > bestLvl) begin
			bestLvl = frtLvl;
			bestVec = cmpVec;
			found = 1'b1;
		end
		if (frtOvfIrq && frtLvl > bestLvl) begin
			bestLvl = frtLvl;
			bestVec = ovfVec;
			found = 1'b1;
		end
		if (itmIrq && itmLvl > bestLvl) begin
			bestLvl = itmLvl;
			bestVec = itmVec;
			found = 1'b1;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			intReq <= 1'b0;
			intLvl <= '0;
			intVec <= '0;
		end else begin
			intReq <= found;
			intLvl <= found ? bestLvl : '0;
			intVec <= found ? bestVec : '0;
		end
	end

endmodule

`default_nettype wire

//--- src/intervalTimer.sv
`timescale 1ns/1ps
`default_nettype none

module intervalTimer import periphPkg::*; #(
	parameter int ITM_WIDTH = 8
) (
	input  wire                CLK,
	input  wire                RST_N,
	input  wire regReq_t       regReq,
	input  wire                sel,
	input  wire prescaleTaps_t taps,
	output regData_t           rdData,
	output logic               irq
);

	logic [ITM_WIDTH-1:0] count;
	logic                 run;
	logic [1:0]           clkSel;
	logic                 irqEn;
	logic                 ovfFlag;
	logic                 tick;
	logic                 wrap;
	logic                 wrEn;

	assign wrEn = sel && regReq.write;

	always_comb begin
		case (clkSel)
			2'd0: tick = run && taps.ce64;
			2'd1: tick = run && taps.ce256;
			2'd2: tick = run && taps.ce1024;
			default: tick = run && taps.ce4096;
		endcase
	end

	assign wrap = tick && count == '1;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			count <= '0;
			run <= 1'b0;
			clkSel <= '0;
			irqEn <= 1'b0;
			ovfFlag <= 1'b0;
		end else begin
			if (wrEn && regReq.offset == 2'd0)
				count <= regReq.wrData[ITM_WIDTH-1:0];
			else if (tick)
				count <= count + 1'b1;

			if (wrEn && regReq.offset == 2'd1) begin
				run <= regReq.wrData[0];
				clkSel <= regReq.wrData[2:1];
				irqEn <= regReq.wrData[3];
			end

			ovfFlag <= (ovfFlag && !(wrEn && regReq.offset == 2'd2 && regReq.wrData[0])) || wrap;
		end
	end

	// Count is zero-extended to the bus width
	always_comb begin
		rdData = '0;
		case (regReq.offset)
			2'd0: rdData[ITM_WIDTH-1:0] = count;
			2'd1: rdData[3:0] = {irqEn, clkSel, run};
			2'd2: rdData[0] = ovfFlag;
			default: rdData = '0;
		endcase
	end

	assign irq = ovfFlag && irqEn;

endmodule

`default_nettype wire

//--- src/onChipPeriph.sv
`timescale 1ns/1ps
`default_nettype none

module onChipPeriph import periphPkg::*; #(
	parameter int ITM_WIDTH = 8
) (
	input  wire           CLK,
	input  wire           RST_N,
	input  wire           req,
	output logic          ack,
	input  wire regAddr_t addr,
	input  wire           wr,
	input  wire regData_t wrData,
	output regData_t      rdData,
	output logic          intReq,
	output intLevel_t     intLvl,
	output intVector_t    intVec
);

	regReq_t       regReq;
	prescaleTaps_t taps;
	logic          selFrt;
	logic          selItm;
	logic          selIntc;
	regData_t      frtRdData;
	regData_t      itmRdData;
	regData_t      intcRdData;
	logic          frtCmpIrq;
	logic          frtOvfIrq;
	logic          itmIrq;

	prescaler u_prescaler (
		.CLK(CLK),
		.RST_N(RST_N),
		.taps(taps)
	);

	periphBus u_periphBus (
		.CLK(CLK),
		.RST_N(RST_N),
		.req(req),
		.ack(ack),
		.addr(addr),
		.wr(wr),
		.wrData(wrData),
		.rdData(rdData),
		.regReq(regReq),
		.selFrt(selFrt),
		.selItm(selItm),
		.selIntc(selIntc),
		.frtRdData(frtRdData),
		.itmRdData(itmRdData),
		.intcRdData(intcRdData)
	);

	freeRunTimer u_freeRunTimer (
		.CLK(CLK),
		.RST_N(RST_N),
		.regReq(regReq),
		.sel(selFrt),
		.taps(taps),
		.rdData(frtRdData),
		.cmpIrq(frtCmpIrq),
		.ovfIrq(frtOvfIrq)
	);

	intervalTimer #(
		.ITM_WIDTH(ITM_WIDTH)
	) u_intervalTimer (
		.CLK(CLK),
		.RST_N(RST_N),
		.regReq(regReq),
		.sel(selItm),
		.taps(taps),
		.rdData(itmRdData),
		.irq(itmIrq)
	);

	intController u_intController (
		.CLK(CLK),
		.RST_N(RST_N),
		.regReq(regReq),
		.sel(selIntc),
		.rdData(intcRdData),
		.frtCmpIrq(frtCmpIrq),
		.frtOvfIrq(frtOvfIrq),
		.itmIrq(itmIrq),
		.intReq(intReq),
		.intLvl(intLvl),
		.intVec(intVec)
	);

endmodule

`default_nettype wire

//--- src/periphBus.sv
`timescale 1ns/1ps
`default_nettype none

module periphBus import periphPkg::*; (
	input  wire           CLK,
	input  wire           RST_N,
	input  wire           req,
	output logic          ack,
	input  wire regAddr_t addr,
	input  wire           wr,
	input  wire regData_t wrData,
	output regData_t      rdData,
	output regReq_t       regReq,
	output logic          selFrt,
	output logic          selItm,
	output logic          selIntc,
	input  wire regData_t frtRdData,
	input  wire regData_t itmRdData,
	input  wire regData_t intcRdData
);

	busState_t state;
	regAddr_t  addrQ;
	regData_t  wrDataQ;
	logic      wrQ;
	logic      hitFrt;
	logic      hitItm;
	logic      hitIntc;
	regData_t  selData;

	// Host request is held here for the whole transaction
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			addrQ <= '0;
			wrDataQ <= '0;
			wrQ <= 1'b0;
		end else if (state == IDLE && req) begin
			addrQ <= addr;
			wrDataQ <= wrData;
			wrQ <= wr;
		end
	end

	assign hitFrt = blockHit(addrQ, FRT_BASE);
	assign hitItm = blockHit(addrQ, ITM_BASE);
	assign hitIntc = blockHit(addrQ, INTC_BASE);

	assign regReq.offset = addrQ[1:0];
	assign regReq.wrData = wrDataQ;
	assign regReq.write = wrQ;

	// Unmapped addresses read as zero
	always_comb begin
		selData = '0;
		if (hitFrt)
			selData = frtRdData;
		else if (hitItm)
			selData = itmRdData;
		else if (hitIntc)
			selData = intcRdData;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= IDLE;
			ack <= 1'b0;
			rdData <= '0;
			selFrt <= 1'b0;
			selItm <= 1'b0;
			selIntc <= 1'b0;
		end else begin
			selFrt <= 1'b0;
			selItm <= 1'b0;
			selIntc <= 1'b0;
			case (state)
				IDLE: begin
					if (req)
						state <= ACCESS;
				end
				ACCESS: begin
					// One strobe, blocks act on it at the next edge
					selFrt <= hitFrt;
					selItm <= hitItm;
					selIntc <= hitIntc;
					state <= HOLD;
				end
				HOLD: begin
					if (!ack) begin
						ack <= 1'b1;
						rdData <= selData;
					end else if (!req) begin
						state <= RELEASE;
					end
				end
				RELEASE: begin
					ack <= 1'b0;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/periphPkg.sv
`default_nettype none

package periphPkg;

	// Widths with a meaning of their own
	typedef logic [7:0]  regAddr_t;
	typedef logic [15:0] regData_t;
	typedef logic [1:0]  regOffset_t;
	typedef logic [3:0]  intLevel_t;
	typedef logic [7:0]  intVector_t;

	// Block bases, upper six bits pick the block and the low two the register
	localparam regAddr_t FRT_BASE  = 8'h10;
	localparam regAddr_t ITM_BASE  = 8'h20;
	localparam regAddr_t INTC_BASE = 8'h30;

	// Register access as seen by every block
	typedef struct packed {
		regOffset_t offset;
		regData_t   wrData;
		logic       write;
	} regReq_t;

	// Single-cycle clock enables from the prescaler
	typedef struct packed {
		logic ce8;
		logic ce32;
		logic ce128;
		logic ce64;
		logic ce256;
		logic ce1024;
		logic ce4096;
	} prescaleTaps_t;

	typedef enum logic [1:0] {
		IDLE,
		ACCESS,
		HOLD,
		RELEASE
	} busState_t;

	function automatic logic blockHit(regAddr_t addr, regAddr_t base);
		return addr[7:2] == base[7:2];
	endfunction

endpackage

`default_nettype wire

//--- src/prescaler.sv
`timescale 1ns/1ps
`default_nettype none

module prescaler import periphPkg::*; (
	input  wire           CLK,
	input  wire           RST_N,
	output prescaleTaps_t taps
);

	logic [12:0] divCnt;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			divCnt <= '0;
			taps <= '0;
		end else begin
			divCnt <= divCnt + 13'd1;

			// Each enable fires once per wrap of its low counter bits
			taps.ce8    <= &divCnt[2:0];
			taps.ce32   <= &divCnt[4:0];
			taps.ce64   <= &divCnt[5:0];
			taps.ce128  <= &divCnt[6:0];
			taps.ce256  <= &divCnt[7:0];
			taps.ce1024 <= &divCnt[9:0];
			taps.ce4096 <= &divCnt[11:0];
		end
	end

endmodule

`default_nettype wire

//--- test/onChipPeriph_props.sv
`timescale 1ns/1ps
`default_nettype none

module onChipPeriph_props (
	input wire CLK,
	input wire RST_N,
	input wire req,
	input wire ack,
	input wire selFrt,
	input wire selItm,
	input wire selIntc
);

	logic anySel;

	assign anySel = selFrt || selItm || selIntc;

	// Acknowledge only answers a raised request
	ackNeedsReq: assert property (@(posedge CLK) disable iff (!RST_N)
		$rose(ack) |-> $past(req))
		else $error("ack rose while req was low");

	ackFallsAfterReq: assert property (@(posedge CLK) disable iff (!RST_N)
		$fell(ack) |-> !$past(req))
		else $error("ack fell before req was seen low");

	// One block strobed for a single cycle, inside a transaction
	oneSelect: assert property (@(posedge CLK) disable iff (!RST_N)
		$onehot0({selFrt, selItm, selIntc}))
		else $error("select lines overlap");

	selInTransaction: assert property (@(posedge CLK) disable iff (!RST_N)
		anySel |-> req && !ack)
		else $error("select line pulsed outside a transaction");

	selPulse: assert property (@(posedge CLK) disable iff (!RST_N) anySel |=> !anySel)
		else $error("select line held longer than one cycle");

	ackInReset: assert property (@(posedge CLK) !RST_N |-> !ack)
		else $error("ack high during reset");

endmodule

bind periphBus onChipPeriph_props u_props (
	.CLK(CLK),
	.RST_N(RST_N),
	.req(req),
	.ack(ack),
	.selFrt(selFrt),
	.selItm(selItm),
	.selIntc(selIntc)
);

`default_nettype wire

//--- test/periph_vectors.txt
# op addr data expected (hex). W writes data, R reads and compares with expected,
# I waits for intReq with level in the data column and vector in expected (level 0 = no request)
W 10 FFFF 0000
R 10 0000 FFFF
W 11 A5C3 0000
R 11 0000 A5C3
W 12 FFFC 0000
R 12 0000 0034
W 12 0000 0000
W 13 0003 0000
R 13 0000 0000
W 20 FFFF 0000
R 20 0000 00FF
W 21 FFFE 0000
R 21 0000 000E
W 21 0000 0000
W 23 FFFF 0000
R 23 0000 0000
W 30 FFFF 0000
R 30 0000 00FF
W 31 1234 0000
R 31 0000 1234
W 32 FFFF 0000
R 32 0000 00FF
W 33 FFFF 0000
R 33 0000 000F
W 44 FFFF 0000
R 44 0000 0000
W 14 0000 0000
R 10 0000 FFFF
# timer level 2, interval level 5, then mask and tie order
W 30 0052 0000
W 31 2221 0000
W 32 0030 0000
W 33 0000 0000
W 10 0000 0000
W 11 0004 0000
W 12 0011 0000
I 00 0002 0021
W 20 00FF 0000
W 21 0009 0000
I 00 0005 0030
R 13 0000 0001
R 22 0000 0001
W 33 0005 0000
I 00 0000 0000
W 30 0056 0000
I 00 0006 0021
W 33 0006 0000
I 00 0000 0000
W 33 0000 0000
W 30 0055 0000
I 00 0005 0021
W 13 0001 0000
I 00 0005 0030
W 22 0001 0000
I 00 0000 0000

//--- test/tb_onChipPeriph.sv
`timescale 1ns/1ps
`default_nettype none

module tb_onChipPeriph import periphPkg::*; ;

	localparam int ACK_LIMIT = 64;
	localparam int POLL_LIMIT = 400;
	localparam int IRQ_LIMIT = 2000;

	logic       CLK;
	logic       RST_N;
	logic       req;
	logic       ack;
	regAddr_t   addr;
	logic       wr;
	regData_t   wrData;
	regData_t   rdData;
	logic       intReq;
	intLevel_t  intLvl;
	intVector_t intVec;

	int       passCount;
	int       failCount;
	int       testStart;
	int       seed;
	regData_t readBack;
	regData_t cmpValue;

	onChipPeriph #(
		.ITM_WIDTH(8)
	) u_onChipPeriph (
		.CLK(CLK),
		.RST_N(RST_N),
		.req(req),
		.ack(ack),
		.addr(addr),
		.wr(wr),
		.wrData(wrData),
		.rdData(rdData),
		.intReq(intReq),
		.intLvl(intLvl),
		.intVec(intVec)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	task automatic checkValue(input string name, input regData_t expected, input regData_t actual);
		if (actual !== expected) begin
			$display("ERR %0t ns %s expected 0x%04h actual 0x%04h", $time, name, expected, actual);
			failCount++;
		end else begin
			passCount++;
		end
	endtask

	task automatic finishRun();
		$display("Checks passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	endtask

	task automatic endTest(input string name, input int errorsBefore);
		$display("Test %s finished with %0d errors", name, failCount - errorsBefore);
	endtask

	task automatic applyReset();
		RST_N = 1'b0;
		repeat (16) @(negedge CLK);
		RST_N = 1'b1;
		@(negedge CLK);
	endtask

	// Four-phase handshake, inputs change on the falling edge only
	task automatic busAccess(input logic isWrite, input regAddr_t a, input regData_t d,
			output regData_t q);
		int waited;
		@(negedge CLK);
		addr = a;
		wr = isWrite;
		wrData = d;
		req = 1'b1;
		waited = 0;
		while (ack !== 1'b1 && waited < ACK_LIMIT) begin
			@(negedge CLK);
			waited++;
		end
		if (ack !== 1'b1) begin
			$display("Bus access to address 0x%02h got no acknowledge", a);
			failCount++;
			finishRun();
		end else begin
			q = rdData;
			req = 1'b0;
			waited = 0;
			while (ack !== 1'b0 && waited < ACK_LIMIT) begin
				@(negedge CLK);
				waited++;
			end
			if (ack !== 1'b0) begin
				$display("Acknowledge for address 0x%02h stayed high after the request ended", a);
				failCount++;
				finishRun();
			end
		end
	endtask

	task automatic busWrite(input regAddr_t a, input regData_t d);
		regData_t unused;
		busAccess(1'b1, a, d, unused);
	endtask

	task automatic busRead(input regAddr_t a, output regData_t q);
		busAccess(1'b0, a, '0, q);
	endtask

	// Level zero stands for no request pending at all
	task automatic waitInterrupt(input intLevel_t lvl, input intVector_t vec);
		logic expReq;
		int   waited;
		expReq = (lvl != 4'd0);
		waited = 0;
		while (!(intReq === expReq && intLvl === lvl && intVec === vec)
				&& waited < IRQ_LIMIT) begin
			@(negedge CLK);
			waited++;
		end
		if (intReq === expReq && intLvl === lvl && intVec === vec) begin
			passCount++;
		end else begin
			$display("Wait for interrupt level %0d vector 0x%02h timed out", lvl, vec);
			checkValue("intReq", {15'd0, expReq}, {15'd0, intReq});
			checkValue("intLvl", {12'd0, lvl}, {12'd0, intLvl});
			checkValue("intVec", {8'd0, vec}, {8'd0, intVec});
		end
	endtask

	task automatic pollCompareFlag();
		int       polls;
		bit       seen;
		regData_t status;
		polls = 0;
		seen = 1'b0;
		while (!seen && polls < POLL_LIMIT) begin
			busRead(FRT_BASE + 8'd3, status);
			seen = status[0];
			polls++;
		end
		if (!seen) begin
			$display("Compare flag of the free-running timer never came up");
			failCount++;
		end
	endtask

	// COMPARE between 4 and 63
	task automatic pickCompare(output regData_t value);
		int r;
		r = {$random(seed)} % 60;
		value = regData_t'(4 + r);
	endtask

	task automatic runVectors();
		int       fd;
		int       code;
		int       fields;
		int       lineNo;
		int       vAddr;
		int       vData;
		int       vExp;
		string    line;
		string    op;
		regData_t q;
		fd = $fopen("test/periph_vectors.txt", "r");
		if (fd == 0) begin
			$display("Vector file test/periph_vectors.txt could not be opened");
			failCount++;
			return;
		end
		lineNo = 0;
		while (!$feof(fd)) begin
			line = "";
			code = $fgets(line, fd);
			lineNo++;
			fields = $sscanf(line, "%s %h %h %h", op, vAddr, vData, vExp);
			if (code == 0 || line.len() == 0 || line.getc(0) == "#" || fields != 4)
				continue;
			case (op)
				"W": busWrite(regAddr_t'(vAddr), regData_t'(vData));
				"R": begin
					busRead(regAddr_t'(vAddr), q);
					checkValue($sformatf("rdData[0x%02h]", vAddr), regData_t'(vExp), q);
				end
				"I": waitInterrupt(intLevel_t'(vData), intVector_t'(vExp));
				default: begin
					$display("Vector line %0d has unknown operation %s", lineNo, op);
					failCount++;
				end
			endcase
		end
		$fclose(fd);
	endtask

	initial begin
		seed = 32'h7dcd;
		passCount = 0;
		failCount = 0;
		RST_N = 1'b0;
		req = 1'b0;
		addr = '0;
		wr = 1'b0;
		wrData = '0;
		applyReset();

		// Reset values of the outputs and every register
		testStart = failCount;
		checkValue("ack", 16'd0, {15'd0, ack});
		checkValue("intReq", 16'd0, {15'd0, intReq});
		for (int blk = 1; blk <= 3; blk++) begin
			for (int off = 0; off < 4; off++) begin
				busRead(regAddr_t'(16 * blk + off), readBack);
				checkValue($sformatf("rdData[0x%02h]", 16 * blk + off), 16'd0, readBack);
			end
		end
		endTest("reset values", testStart);

		testStart = failCount;
		runVectors();
		endTest("register map and priority vectors", testStart);

		// Compare match with a random COMPARE and its interrupt
		applyReset();
		testStart = failCount;
		busWrite(INTC_BASE, 16'h0003);
		busWrite(INTC_BASE + 8'd1, 16'h4241);
		busWrite(FRT_BASE, 16'h1234);
		busRead(FRT_BASE, readBack);
		checkValue("frt COUNT", 16'h1234, readBack);
		busWrite(FRT_BASE, 16'h0000);
		pickCompare(cmpValue);
		busWrite(FRT_BASE + 8'd1, cmpValue);
		busWrite(FRT_BASE + 8'd2, 16'h0011);
		pollCompareFlag();
		waitInterrupt(4'd3, 8'h41);
		busWrite(FRT_BASE + 8'd3, 16'h0001);
		waitInterrupt(4'd0, 8'h00);
		endTest("timer compare interrupt", testStart);

		// Clear on match keeps the count inside 0..COMPARE
		applyReset();
		testStart = failCount;
		pickCompare(cmpValue);
		busWrite(FRT_BASE + 8'd1, cmpValue);
		busWrite(FRT_BASE + 8'd2, 16'h0005);
		pollCompareFlag();
		busWrite(FRT_BASE + 8'd3, 16'h0001);
		busWrite(FRT_BASE, 16'h0000);
		pollCompareFlag();
		busRead(FRT_BASE, readBack);
		if (readBack > cmpValue) begin
			$display("ERR %0t ns frt COUNT expected at most 0x%04h actual 0x%04h",
				$time, cmpValue, readBack);
			failCount++;
		end else begin
			passCount++;
		end
		endTest("clear on compare", testStart);

		finishRun();
	end

endmodule

`default_nettype wire
